//--- sim.f
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_btb.sv
rtl/fetch_ras.sv
rtl/fetch_stage_if_sram.sv
rtl/fetch_top.sv
tb/fetch_clk_gen.sv
tb/fetch_assertions.sv
tb/fetch_tb.sv

//--- Makefile
TOP := fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- tb/fetch_tb.sv
`default_nettype none

module fetch_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int               BTB_ENTRIES = 16;
  localparam int               RAS_DEPTH   = 4;
  localparam fetch_pkg::addr_t RESET_PC    = 32'h0000_0000;
  localparam int               IDX_W       = $clog2(BTB_ENTRIES);

  // Random addresses stay in a small word-aligned window so BTB lines get reused
  localparam fetch_pkg::addr_t REGION_MASK = 32'h0000_00FC;

  // Phase lengths in cycles
  localparam int N_STRAIGHT = 40;
  localparam int N_STALL    = 200;
  localparam int N_REDIRECT = 200;
  localparam int N_BTB      = 300;
  localparam int N_RAS      = 400;
  localparam int TOTAL_CYCLES = 4 + N_STRAIGHT + N_STALL + N_REDIRECT + N_BTB + N_RAS;
  localparam int TIMEOUT_CYCLES = TOTAL_CYCLES * 3 / 2;

  logic                 clk;
  logic                 rst_n;
  logic                 advance;
  logic                 redirect;
  fetch_pkg::addr_t     redirect_pc;
  logic                 btb_upd;
  fetch_pkg::addr_t     btb_upd_pc;
  fetch_pkg::addr_t     btb_upd_tgt;
  logic                 btb_upd_taken;
  logic                 btb_upd_return;
  logic                 ras_push;
  fetch_pkg::addr_t     ras_push_addr;
  logic                 ras_pop;
  logic                 imem_ren;
  fetch_pkg::addr_t     imem_raddr;
  fetch_pkg::instr_t    imem_rdata;
  fetch_pkg::fetch_id_t id;

  int seed = 27;
  int cycle_count = 0;

  // Reference model state
  fetch_pkg::addr_t     m_pc;
  logic                 m_started;
  fetch_pkg::fetch_id_t exp_id;
  logic                 b_valid [BTB_ENTRIES];
  fetch_pkg::addr_t     b_pc    [BTB_ENTRIES];
  fetch_pkg::addr_t     b_tgt   [BTB_ENTRIES];
  logic                 b_taken [BTB_ENTRIES];
  logic                 b_ret   [BTB_ENTRIES];
  // Back of the queue is the stack top
  fetch_pkg::addr_t     ras_q [$];

  fetch_clk_gen u_clk_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  fetch_top #(
    .BTB_ENTRIES(BTB_ENTRIES),
    .RAS_DEPTH  (RAS_DEPTH),
    .PIPELINED  (1),
    .RESET_PC   (RESET_PC)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .advance       (advance),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .btb_upd       (btb_upd),
    .btb_upd_pc    (btb_upd_pc),
    .btb_upd_tgt   (btb_upd_tgt),
    .btb_upd_taken (btb_upd_taken),
    .btb_upd_return(btb_upd_return),
    .ras_push      (ras_push),
    .ras_push_addr (ras_push_addr),
    .ras_pop       (ras_pop),
    .imem_ren      (imem_ren),
    .imem_raddr    (imem_raddr),
    .imem_rdata    (imem_rdata),
    .id            (id)
  );

  // SRAM word mixes every address bit through an odd multiply
  function automatic fetch_pkg::instr_t sram_word(input fetch_pkg::addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h1357_2468;
  endfunction

  assign imem_rdata = sram_word(imem_raddr);

  function automatic int roll_16();
    return $random(seed) & 15;
  endfunction

  // Stop the run if the phases never complete
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1, "Timeout");
    end
  end

  task automatic check_id(input fetch_pkg::fetch_id_t exp, input fetch_pkg::fetch_id_t act);
    fetch_pkg::fetch_id_t masked;
    masked = act;
    // Targets mean nothing while their flag is low
    if (!exp.btb_hit) begin
      masked.btb_tgt = exp.btb_tgt;
    end
    if (!exp.ras_valid) begin
      masked.ras_tgt = exp.ras_tgt;
    end
    if (masked !== exp) begin
      $display("[ERROR] %t id mismatch (expected/actual) valid %b/%b instr %h/%h pc %h/%h",
               $realtime, exp.valid, act.valid, exp.instr, act.instr, exp.pc, act.pc);
      $display("  pc_plus4 %h/%h hit %b/%b taken %b/%b ret %b/%b ras_valid %b/%b",
               exp.pc_plus4, act.pc_plus4, exp.btb_hit, act.btb_hit,
               exp.pred_taken, act.pred_taken, exp.is_return, act.is_return,
               exp.ras_valid, act.ras_valid);
      $display("  btb_tgt %h/%h ras_tgt %h/%h", exp.btb_tgt, act.btb_tgt,
               exp.ras_tgt, act.ras_tgt);
      $display("Something failed");
      $fatal(1, "ID bundle mismatch");
    end
  endtask

  task automatic check_addr(input string name, input fetch_pkg::addr_t exp,
                            input fetch_pkg::addr_t act);
    if (act !== exp) begin
      $display("[ERROR] %t %s expected %h got %h", $realtime, name, exp, act);
      $display("Something failed");
      $fatal(1, "Address mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %t %s expected %b got %b", $realtime, name, exp, act);
      $display("Something failed");
      $fatal(1, "Control bit mismatch");
    end
  endtask

  task automatic init_model();
    m_pc      = RESET_PC;
    m_started = 1'b0;
    exp_id    = '0;
    exp_id.instr    = fetch_pkg::I_NOP;
    exp_id.pc       = RESET_PC;
    exp_id.pc_plus4 = RESET_PC + 32'd4;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      b_valid[i] = 1'b0;
    end
    ras_q.delete();
  endtask

  // Advance the model over one rising edge using the inputs held before it
  task automatic step_model();
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] uidx;
    logic             hit;
    logic             taken;
    logic             ret;
    logic             rv;
    fetch_pkg::addr_t tgt;
    fetch_pkg::addr_t rtop;
    fetch_pkg::addr_t next_pc;
    // Lookup sees the predictor state from before the edge
    idx   = m_pc[IDX_W+1:2];
    hit   = b_valid[idx] && (b_pc[idx][31:2] == m_pc[31:2]);
    taken = hit && b_taken[idx];
    ret   = hit && b_ret[idx];
    tgt   = b_tgt[idx];
    rv    = ras_q.size() > 0;
    rtop  = '0;
    if (rv) begin
      rtop = ras_q[ras_q.size()-1];
    end
    // Redirect, then RAS return, then BTB target, then sequential
    if (redirect) begin
      next_pc = redirect_pc;
    end else if (taken && ret && rv) begin
      next_pc = rtop;
    end else if (taken) begin
      next_pc = tgt;
    end else begin
      next_pc = m_pc + 32'd4;
    end
    // Flush wins over a stall in the IF/ID bundle
    if (redirect) begin
      exp_id            = '0;
      exp_id.instr      = fetch_pkg::I_NOP;
      exp_id.pc         = RESET_PC;
      exp_id.pc_plus4   = RESET_PC + 32'd4;
    end else if (advance) begin
      exp_id.instr      = sram_word(m_pc);
      exp_id.valid      = m_started;
      exp_id.pc         = m_pc;
      exp_id.pc_plus4   = m_pc + 32'd4;
      exp_id.btb_hit    = hit;
      exp_id.pred_taken = taken;
      exp_id.is_return  = ret;
      exp_id.ras_valid  = rv;
      exp_id.btb_tgt    = tgt;
      exp_id.ras_tgt    = rtop;
    end
    if (redirect || advance) begin
      m_pc = next_pc;
    end
    m_started = 1'b1;
    // Predictor writes land after the lookup
    if (btb_upd) begin
      uidx          = btb_upd_pc[IDX_W+1:2];
      b_valid[uidx] = 1'b1;
      b_pc[uidx]    = btb_upd_pc;
      b_tgt[uidx]   = btb_upd_tgt;
      b_taken[uidx] = btb_upd_taken;
      b_ret[uidx]   = btb_upd_return;
    end
    if (ras_push && ras_pop && ras_q.size() > 0) begin
      ras_q[ras_q.size()-1] = ras_push_addr;
    end else if (ras_push) begin
      // Full stack drops its oldest entry
      if (ras_q.size() == RAS_DEPTH) begin
        void'(ras_q.pop_front());
      end
      ras_q.push_back(ras_push_addr);
    end else if (ras_pop && ras_q.size() > 0) begin
      void'(ras_q.pop_back());
    end
  endtask

  // Odds are in sixteenths
  task automatic drive_random(input int p_stall, input int p_redir, input int p_btb,
                              input int p_ras, input bit use_return);
    advance        = roll_16() >= p_stall;
    redirect       = roll_16() < p_redir;
    redirect_pc    = fetch_pkg::addr_t'($random(seed)) & REGION_MASK;
    btb_upd        = roll_16() < p_btb;
    btb_upd_pc     = fetch_pkg::addr_t'($random(seed)) & REGION_MASK;
    btb_upd_tgt    = fetch_pkg::addr_t'($random(seed)) & REGION_MASK;
    btb_upd_taken  = roll_16() < 11;
    btb_upd_return = use_return && (roll_16() < 8);
    ras_push       = roll_16() < p_ras;
    ras_push_addr  = fetch_pkg::addr_t'($random(seed)) & REGION_MASK;
    ras_pop        = roll_16() < p_ras;
  endtask

  task automatic run_cycles(input int n, input int p_stall, input int p_redir,
                            input int p_btb, input int p_ras, input bit use_return);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      step_model();
      check_id(exp_id, id);
      check_addr("imem_raddr", m_pc, imem_raddr);
      check_bit("imem_ren", 1'b1, imem_ren);
      drive_random(p_stall, p_redir, p_btb, p_ras, use_return);
    end
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    advance        = 1'b0;
    redirect       = 1'b0;
    redirect_pc    = '0;
    btb_upd        = 1'b0;
    btb_upd_pc     = '0;
    btb_upd_tgt    = '0;
    btb_upd_taken  = 1'b0;
    btb_upd_return = 1'b0;
    ras_push       = 1'b0;
    ras_push_addr  = '0;
    ras_pop        = 1'b0;
    init_model();

    // Reset state shows a bubble, a NOP and cleared prediction bits
    // Release lands 1 ns after a rising edge
    wait (rst_n === 1'b1);
    check_id(exp_id, id);
    check_addr("imem_raddr", RESET_PC, imem_raddr);
    check_bit("imem_ren", 1'b1, imem_ren);
    advance = 1'b1;

    // Straight-line fetch, then stalls, redirects, BTB and RAS traffic
    run_cycles(N_STRAIGHT, 0, 0, 0, 0, 1'b0);
    run_cycles(N_STALL, 6, 0, 0, 0, 1'b0);
    run_cycles(N_REDIRECT, 5, 3, 0, 0, 1'b0);
    run_cycles(N_BTB, 3, 2, 4, 0, 1'b0);
    run_cycles(N_RAS, 3, 2, 4, 5, 1'b1);

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/fetch_assertions.sv
`default_nettype none

module fetch_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 advance,
  input logic                 redirect,
  input logic                 imem_ren,
  input fetch_pkg::fetch_id_t id
);

  timeunit 1ns;
  timeprecision 1ps;

  // Zero-latency SRAM is read every cycle
  a_ren_high: assert property (@(posedge clk) disable iff (!rst_n) imem_ren)
    else $error("imem_ren went low");

  // Redirect is also the IF/ID flush, so the next bundle is a bubble
  a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    redirect |=> !id.valid)
    else $error("id.valid high in the cycle after a redirect");

  // Stall without redirect freezes the whole bundle
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!advance && !redirect) |=> $stable(id))
    else $error("id changed while ID was stalled");

endmodule

bind fetch_top fetch_assertions u_assertions (
  .clk     (clk),
  .rst_n   (rst_n),
  .advance (advance),
  .redirect(redirect),
  .imem_ren(imem_ren),
  .id      (id)
);

`default_nettype wire

//--- tb/fetch_clk_gen.sv
`default_nettype none

module fetch_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 4;

  // Free running clock with a 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held over four rising edges, released 1 ns after the last one
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
`default_nettype none

module fetch_top #(
  parameter int               BTB_ENTRIES = 16,
  parameter int               RAS_DEPTH   = 4,
  parameter int               PIPELINED   = 1,
  parameter fetch_pkg::addr_t RESET_PC    = '0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 advance,
  input  logic                 redirect,
  input  fetch_pkg::addr_t     redirect_pc,
  input  logic                 btb_upd,
  input  fetch_pkg::addr_t     btb_upd_pc,
  input  fetch_pkg::addr_t     btb_upd_tgt,
  input  logic                 btb_upd_taken,
  input  logic                 btb_upd_return,
  input  logic                 ras_push,
  input  fetch_pkg::addr_t     ras_push_addr,
  input  logic                 ras_pop,
  output logic                 imem_ren,
  output fetch_pkg::addr_t     imem_raddr,
  input  fetch_pkg::instr_t    imem_rdata,
  output fetch_pkg::fetch_id_t id
);

  // Fetch PC and its bubble flag
  fetch_pkg::addr_t pc;
  logic             valid_if;

  // Predictor answers for the current PC
  logic             btb_hit;
  logic             btb_taken;
  fetch_pkg::addr_t btb_tgt;
  logic             btb_is_return;
  fetch_pkg::addr_t ras_top;
  logic             ras_valid;

  fetch_pc_gen #(
    .PIPELINED(PIPELINED),
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .advance      (advance),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .btb_hit      (btb_hit),
    .btb_taken    (btb_taken),
    .btb_tgt      (btb_tgt),
    .btb_is_return(btb_is_return),
    .ras_valid    (ras_valid),
    .ras_tgt      (ras_top),
    .pc           (pc),
    .valid_if     (valid_if),
    .pc_id        (id.pc),
    .pc_plus4_id  (id.pc_plus4)
  );

  fetch_btb #(
    .BTB_ENTRIES(BTB_ENTRIES)
  ) u_btb (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .upd       (btb_upd),
    .upd_pc    (btb_upd_pc),
    .upd_tgt   (btb_upd_tgt),
    .upd_taken (btb_upd_taken),
    .upd_return(btb_upd_return),
    .hit       (btb_hit),
    .taken     (btb_taken),
    .tgt       (btb_tgt),
    .is_return (btb_is_return)
  );

  fetch_ras #(
    .RAS_DEPTH(RAS_DEPTH)
  ) u_ras (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (ras_push),
    .push_addr(ras_push_addr),
    .pop      (ras_pop),
    .top      (ras_top),
    .valid    (ras_valid)
  );

  // Redirect doubles as the IF/ID flush
  fetch_stage_if_sram #(
    .PIPELINED(PIPELINED)
  ) u_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .valid_if         (valid_if),
    .pc               (pc),
    .if_id_flush      (redirect),
    .advance          (advance),
    .btb_hit_if       (btb_hit),
    .btb_pred_taken_if(btb_taken),
    .btb_tgt_if       (btb_tgt),
    .btb_is_return_if (btb_is_return),
    .ras_valid_if     (ras_valid),
    .ras_tgt_if       (ras_top),
    .imem_rdata       (imem_rdata),
    .imem_ren         (imem_ren),
    .imem_raddr       (imem_raddr),
    .instr_id         (id.instr),
    .btb_hit_id       (id.btb_hit),
    .btb_pred_taken_id(id.pred_taken),
    .btb_tgt_id       (id.btb_tgt),
    .btb_is_return_id (id.is_return),
    .ras_valid_id     (id.ras_valid),
    .ras_tgt_id       (id.ras_tgt),
    .valid_ram        (id.valid)
  );

endmodule

`default_nettype wire

//--- rtl/fetch_stage_if_sram.sv
`default_nettype none

module fetch_stage_if_sram #(
  parameter int PIPELINED = 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_if,
  input  fetch_pkg::addr_t  pc,
  input  logic              if_id_flush,
  input  logic              advance,
  input  logic              btb_hit_if,
  input  logic              btb_pred_taken_if,
  input  fetch_pkg::addr_t  btb_tgt_if,
  input  logic              btb_is_return_if,
  input  logic              ras_valid_if,
  input  fetch_pkg::addr_t  ras_tgt_if,
  input  fetch_pkg::instr_t imem_rdata,
  output logic              imem_ren,
  output fetch_pkg::addr_t  imem_raddr,
  output fetch_pkg::instr_t instr_id,
  output logic              btb_hit_id,
  output logic              btb_pred_taken_id,
  output fetch_pkg::addr_t  btb_tgt_id,
  output logic              btb_is_return_id,
  output logic              ras_valid_id,
  output fetch_pkg::addr_t  ras_tgt_id,
  output logic              valid_ram
);

  // Prediction flags that get cleared with the instruction
  typedef struct packed {
    logic btb_hit;
    logic pred_taken;
    logic is_return;
    logic ras_valid;
  } pred_ctrl_t;

  // Predicted addresses, pure datapath
  typedef struct packed {
    fetch_pkg::addr_t btb_tgt;
    fetch_pkg::addr_t ras_tgt;
  } pred_tgt_t;

  pred_ctrl_t ctrl_if;
  pred_tgt_t  tgt_if;
  pred_ctrl_t ctrl_id;
  pred_tgt_t  tgt_id;

  // Zero-latency SRAM, read every cycle at the current PC
  assign imem_ren   = 1'b1;
  assign imem_raddr = pc;

  assign ctrl_if = '{
    btb_hit:    btb_hit_if,
    pred_taken: btb_pred_taken_if,
    is_return:  btb_is_return_if,
    ras_valid:  ras_valid_if
  };
  assign tgt_if = '{btb_tgt: btb_tgt_if, ras_tgt: ras_tgt_if};

  if (PIPELINED != 0) begin : g_buf
    fetch_pkg::instr_t instr_q;
    logic              valid_q;
    pred_ctrl_t        ctrl_q;
    pred_tgt_t         tgt_q;

    // Flush drops the instruction even while ID is stalled
    always_ff @(posedge clk) begin
      if (!rst_n || if_id_flush) begin
        instr_q <= fetch_pkg::I_NOP;
        valid_q <= 1'b0;
        ctrl_q  <= '0;
      end else if (advance) begin
        instr_q <= imem_rdata;
        // Reset bubble from the PC stage stays invalid
        valid_q <= valid_if;
        ctrl_q  <= ctrl_if;
      end
    end

    // Targets only matter when the flags above say so
    always_ff @(posedge clk) begin
      if (advance) begin
        tgt_q <= tgt_if;
      end
    end

    assign instr_id  = instr_q;
    assign valid_ram = valid_q;
    assign ctrl_id   = ctrl_q;
    assign tgt_id    = tgt_q;
  end else begin : g_pass
    // Straight from the SRAM and predictors into ID
    assign instr_id  = imem_rdata;
    assign valid_ram = rst_n;
    assign ctrl_id   = ctrl_if;
    assign tgt_id    = tgt_if;
  end

  assign btb_hit_id        = ctrl_id.btb_hit;
  assign btb_pred_taken_id = ctrl_id.pred_taken;
  assign btb_is_return_id  = ctrl_id.is_return;
  assign ras_valid_id      = ctrl_id.ras_valid;
  assign btb_tgt_id        = tgt_id.btb_tgt;
  assign ras_tgt_id        = tgt_id.ras_tgt;

endmodule

`default_nettype wire

//--- rtl/fetch_ras.sv
`default_nettype none

module fetch_ras #(
  parameter int RAS_DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  fetch_pkg::addr_t push_addr,
  input  logic             pop,
  output fetch_pkg::addr_t top,
  output logic             valid
);

  localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  fetch_pkg::addr_t stack_q [RAS_DEPTH];
  ptr_t             top_q;
  cnt_t             count_q;
  logic             empty;
  logic             full;

  // Wrapping step around the circular array
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(RAS_DEPTH - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  function automatic ptr_t ptr_dec(ptr_t p);
    return (p == '0) ? ptr_t'(RAS_DEPTH - 1) : p - ptr_t'(1);
  endfunction

  assign empty = (count_q == '0);
  assign full  = (count_q == cnt_t'(RAS_DEPTH));

  // Pointer and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (push && pop && !empty) begin
      // Replace the top, depth unchanged
      top_q   <= top_q;
      count_q <= count_q;
    end else if (push) begin
      // Full stack wraps onto the oldest slot
      top_q <= ptr_inc(top_q);
      if (!full) begin
        count_q <= count_q + cnt_t'(1);
      end
    end else if (pop && !empty) begin
      top_q   <= ptr_dec(top_q);
      count_q <= count_q - cnt_t'(1);
    end
  end

  // Return addresses, no reset on the array
  always_ff @(posedge clk) begin
    if (push && pop && !empty) begin
      stack_q[top_q] <= push_addr;
    end else if (push) begin
      stack_q[ptr_inc(top_q)] <= push_addr;
    end
  end

  assign top   = stack_q[top_q];
  assign valid = !empty;

endmodule

`default_nettype wire

//--- rtl/fetch_btb.sv
`default_nettype none

module fetch_btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  fetch_pkg::addr_t pc,
  input  logic             upd,
  input  fetch_pkg::addr_t upd_pc,
  input  fetch_pkg::addr_t upd_tgt,
  input  logic             upd_taken,
  input  logic             upd_return,
  output logic             hit,
  output logic             taken,
  output fetch_pkg::addr_t tgt,
  output logic             is_return
);

  // Word-aligned PCs, so the index starts above bit 1
  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = fetch_pkg::XLEN - IDX_W - 2;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // One BTB line without its valid bit
  typedef struct packed {
    tag_t             tag;
    fetch_pkg::addr_t tgt;
    logic             taken;
    logic             is_return;
  } btb_entry_t;

  logic [BTB_ENTRIES-1:0] valid_q;
  btb_entry_t             entry_q [BTB_ENTRIES];

  idx_t       rd_idx;
  tag_t       rd_tag;
  idx_t       wr_idx;
  tag_t       wr_tag;
  btb_entry_t rd_entry;

  // Split the lookup and update addresses into index and tag
  assign rd_idx = pc[IDX_W+1:2];
  assign rd_tag = pc[fetch_pkg::XLEN-1:IDX_W+2];
  assign wr_idx = upd_pc[IDX_W+1:2];
  assign wr_tag = upd_pc[fetch_pkg::XLEN-1:IDX_W+2];

  // Valid bits are the only state that needs a clean start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Entry payload, written whole on every update
  always_ff @(posedge clk) begin
    if (upd) begin
      entry_q[wr_idx] <= '{
        tag:       wr_tag,
        tgt:       upd_tgt,
        taken:     upd_taken,
        is_return: upd_return
      };
    end
  end

  // Combinational lookup in the same cycle as the fetch
  assign rd_entry = entry_q[rd_idx];
  assign hit      = valid_q[rd_idx] && (rd_entry.tag == rd_tag);

  // Flags are qualified by hit so stale lines never predict
  assign taken     = hit && rd_entry.taken;
  assign is_return = hit && rd_entry.is_return;
  assign tgt       = rd_entry.tgt;

endmodule

`default_nettype wire

//--- rtl/fetch_pc_gen.sv
`default_nettype none

module fetch_pc_gen #(
  parameter int               PIPELINED = 1,
  parameter fetch_pkg::addr_t RESET_PC  = '0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             advance,
  input  logic             redirect,
  input  fetch_pkg::addr_t redirect_pc,
  input  logic             btb_hit,
  input  logic             btb_taken,
  input  fetch_pkg::addr_t btb_tgt,
  input  logic             btb_is_return,
  input  logic             ras_valid,
  input  fetch_pkg::addr_t ras_tgt,
  output fetch_pkg::addr_t pc,
  output logic             valid_if,
  output fetch_pkg::addr_t pc_id,
  output fetch_pkg::addr_t pc_plus4_id
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t pc_plus4;
  fetch_pkg::addr_t pc_next;
  logic             started_q;
  logic             take_btb;
  logic             take_ras;

  assign pc_plus4 = pc_q + fetch_pkg::addr_t'(4);

  // Taken BTB hit steers fetch to the stored target
  assign take_btb = btb_hit && btb_taken;

  // Return entries prefer the RAS top, but only when the stack has one
  assign take_ras = take_btb && btb_is_return && ras_valid;

  // Next PC priority: redirect, RAS return, BTB target, sequential
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (take_ras) begin
      pc_next = ras_tgt;
    end else if (take_btb) begin
      pc_next = btb_tgt;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // Fetch PC, a redirect wins even while ID is stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect || advance) begin
      pc_q <= pc_next;
    end
  end

  // One bubble cycle right after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
    end
  end

  assign pc       = pc_q;
  assign valid_if = started_q;

  // IF/ID copy of the PC, flushed together with the stage buffers
  if (PIPELINED != 0) begin : g_id_reg
    fetch_pkg::addr_t pc_id_q;

    always_ff @(posedge clk) begin
      if (!rst_n || redirect) begin
        pc_id_q <= RESET_PC;
      end else if (advance) begin
        pc_id_q <= pc_q;
      end
    end

    assign pc_id = pc_id_q;
  end else begin : g_id_pass
    assign pc_id = pc_q;
  end

  // Fall-through address always follows the PC that ID sees
  assign pc_plus4_id = pc_id + fetch_pkg::addr_t'(4);

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Address width of the core
  localparam int XLEN = 32;

  // Instruction word width, fixed for RV32 without compressed encodings
  localparam int ILEN = 32;

  // PC, branch target or return address
  typedef logic [XLEN-1:0] addr_t;

  // Raw instruction word as read from the SRAM
  typedef logic [ILEN-1:0] instr_t;

  // addi x0, x0, 0
  // Fills the IF/ID buffer on reset and flush
  localparam instr_t I_NOP = 32'h0000_0013;

  // Bundle handed from fetch to decode
  typedef struct packed {
    // Fetched instruction, NOP when invalid
    instr_t instr;

    // Address of the instruction and its fall-through
    addr_t  pc;
    addr_t  pc_plus4;

    // BTB found a matching entry for pc
    logic   btb_hit;

    // BTB predicted the branch taken
    logic   pred_taken;

    // BTB marked the entry as a function return
    logic   is_return;

    // RAS held at least one address at fetch time
    logic   ras_valid;

    // Predicted targets, kept for the resolution check in execute
    addr_t  btb_tgt;
    addr_t  ras_tgt;

    // Instruction is real and not a bubble
    logic   valid;
  } fetch_id_t;

endpackage

`default_nettype wire
